// ==== sources.f ====
+incdir+tests
verilog/CorePkg.sv
verilog/IssueGate.sv
verilog/RegFile.sv
verilog/OperandLoad.sv
verilog/ExecUnit.sv
verilog/Writeback.sv
verilog/Core.sv
tests/tb_Core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_Core -f sources.f --Mdir obj_dir -o simCore
./obj_dir/simCore | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

// ==== tests/tbUtil.svh ====
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

logic [31:0] lfsrState;

// Reference register state, updated in program order
logic [XLEN-1:0] modelRegs [NUM_REGS];

// Expected writeback per sequence number
logic [XLEN-1:0] expValue [2**SQN_W];
logic [TAG_W-1:0] expTag [2**SQN_W];
int issuedSqN [2**SQN_W];

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function logic [31:0] randBits(input int n);
    logic [31:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
        lfsrState = {lfsrState[30:0],
                     lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
        bits = {bits[30:0], lfsrState[0]};
    end
    return bits;
endfunction

function automatic logic [XLEN-1:0] aluModel(
    input AluOp op,
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
);
    case (op)
        OP_ADD: return a + b;
        OP_SUB: return a - b;
        OP_AND: return a & b;
        OP_XOR: return a ^ b;
        OP_SLT: return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
        OP_MUL: return a * b;
        default: return '0;
    endcase
endfunction

// Scoreboard in the DUT makes completion order irrelevant here
task automatic expectUop(
    input AluOp op,
    input logic [TAG_W-1:0] tagA,
    input logic [TAG_W-1:0] tagB,
    input logic immB,
    input logic [IMM_W-1:0] imm,
    input logic [TAG_W-1:0] dst,
    input logic [SQN_W-1:0] sqn
);
    logic [XLEN-1:0] srcB;
    if (issuedSqN[sqn] != retiredSqN[sqn]) begin
        $display("Sequence number %0d reused while its micro-op is in flight", sqn);
        errors++;
    end
    srcB = immB ? imm : modelRegs[tagB];
    expValue[sqn] = aluModel(op, modelRegs[tagA], srcB);
    expTag[sqn] = dst;
    modelRegs[dst] = expValue[sqn];
    issuedSqN[sqn]++;
    issued++;
endtask

task automatic checkWord(input string name, input logic [XLEN-1:0] actual,
                         input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
        wbErrors++;
    end
endtask

task automatic checkTag(input string name, input logic [TAG_W-1:0] actual,
                        input logic [TAG_W-1:0] expected);
    if (actual !== expected) begin
        $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        wbErrors++;
    end
endtask

task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
        errors++;
    end
endtask

`endif

// ==== tests/tb_Core.sv ====
`timescale 1ns/1ps

module tb_Core
    import CorePkg::*;
();

localparam int NUM_REGS = 64;
localparam int MAX_WAIT = 100;

logic clk;
logic rst;
logic uopReq;
AluOp uopOp;
FuncUnit uopFu;
logic [TAG_W-1:0] uopTagA;
logic [TAG_W-1:0] uopTagB;
logic uopImmB;
logic [IMM_W-1:0] uopImm;
logic [TAG_W-1:0] uopTagDst;
logic [SQN_W-1:0] uopSqN;
logic uopAck;
logic wbValid;
logic [TAG_W-1:0] wbTag;
logic [XLEN-1:0] wbResult;
logic [SQN_W-1:0] wbSqN;

// Main process counters
int errors;
int errorsBefore;
int testCount;
int failedTests;
int issued;
int ackWait;
logic timedOut;
logic [SQN_W-1:0] nextSqN;
logic [TAG_W-1:0] lastDst;

// Writeback monitor counters
int wbErrors = 0;
int retired = 0;
int retiredSqN [2**SQN_W];

`include "tbUtil.svh"

Core #(.NUM_REGS(NUM_REGS)) Core_i (
    .clk(clk), .rst(rst),
    .uopReq(uopReq), .uopOp(uopOp), .uopFu(uopFu),
    .uopTagA(uopTagA), .uopTagB(uopTagB), .uopImmB(uopImmB), .uopImm(uopImm),
    .uopTagDst(uopTagDst), .uopSqN(uopSqN), .uopAck(uopAck),
    .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult), .wbSqN(wbSqN)
);

initial begin
    clk = 1'b0;
    forever begin
        #50 clk = ~clk;
    end
end

task automatic endRun();
    $display("Tests: %0d, tests with errors: %0d, errors: %0d",
             testCount, failedTests, errors + wbErrors);
    if (errors + wbErrors == 0) begin
        $display("Result: PASSED");
    end
    else begin
        $display("Result: FAILED");
    end
    $finish;
endtask

// Later stimulus is skipped once a wait has run out
task automatic timeoutFail(input string what);
    $display("Timeout at %0t: %s", $time, what);
    errors++;
    timedOut = 1'b1;
endtask

// Model sees the micro-op in program order before its four-phase handshake
task automatic sendUop(
    input AluOp op,
    input logic [TAG_W-1:0] tagA,
    input logic [TAG_W-1:0] tagB,
    input logic immB,
    input logic [IMM_W-1:0] imm,
    input logic [TAG_W-1:0] dst
);
    int n;
    if (timedOut) begin
        return;
    end
    expectUop(op, tagA, tagB, immB, imm, dst, nextSqN);
    @(posedge clk);
    uopReq <= 1'b1;
    uopOp <= op;
    uopFu <= (op == OP_MUL) ? FU_MUL : FU_INT;
    uopTagA <= tagA;
    uopTagB <= tagB;
    uopImmB <= immB;
    uopImm <= imm;
    uopTagDst <= dst;
    uopSqN <= nextSqN;
    nextSqN = nextSqN + 1'b1;
    lastDst = dst;
    n = 0;
    @(negedge clk);
    while (!uopAck) begin
        if (n >= MAX_WAIT) begin
            timeoutFail("uopAck did not rise for a pending request");
            return;
        end
        n++;
        @(negedge clk);
    end
    ackWait = n;
    @(posedge clk);
    uopReq <= 1'b0;
    n = 0;
    @(negedge clk);
    while (uopAck) begin
        if (n >= MAX_WAIT) begin
            timeoutFail("uopAck did not fall after uopReq dropped");
            return;
        end
        n++;
        @(negedge clk);
    end
endtask

// Fields drawn in a fixed order so the stream repeats run to run
task automatic sendRandom(input logic forceMul, input logic chain);
    AluOp op;
    logic [TAG_W-1:0] tagA;
    logic [TAG_W-1:0] tagB;
    logic [TAG_W-1:0] dst;
    logic immB;
    logic [IMM_W-1:0] imm;
    op = AluOp'(3'(randBits(3) % 5));
    tagA = TAG_W'(randBits(TAG_W));
    tagB = TAG_W'(randBits(TAG_W));
    immB = 1'(randBits(1));
    imm = randBits(IMM_W);
    dst = TAG_W'(randBits(TAG_W));
    if (forceMul) begin
        op = OP_MUL;
    end
    if (chain) begin
        tagA = lastDst;
    end
    sendUop(op, tagA, tagB, immB, imm, dst);
endtask

task automatic finishTest(input string name);
    int n;
    n = 0;
    while (!timedOut && issued != retired) begin
        if (n >= MAX_WAIT) begin
            timeoutFail($sformatf("%0d results of test %s never reached the wb bus",
                                  issued - retired, name));
        end
        else begin
            n++;
            @(posedge clk);
        end
    end
    testCount++;
    if (errors + wbErrors != errorsBefore) begin
        failedTests++;
        $display("Test %0d %s: %0d errors", testCount, name,
                 errors + wbErrors - errorsBefore);
    end
    else if (timedOut) begin
        $display("Test %0d %s: not run after an earlier timeout", testCount, name);
    end
    else begin
        $display("Test %0d %s: all checks match", testCount, name);
    end
    errorsBefore = errors + wbErrors;
endtask

// Each result must belong to a micro-op still in flight
always @(negedge clk) begin
    if (!rst && wbValid) begin
        if (retiredSqN[wbSqN] == issuedSqN[wbSqN]) begin
            $display("Writeback at %0t for sequence number %0d with no micro-op in flight",
                     $time, wbSqN);
            wbErrors++;
        end
        else begin
            checkTag("wbTag", wbTag, expTag[wbSqN]);
            checkWord("wbResult", wbResult, expValue[wbSqN]);
            retiredSqN[wbSqN]++;
            retired++;
        end
    end
end

initial begin
    int r;
    int k;
    logic [TAG_W-1:0] wawTag;
    logic [TAG_W-1:0] srcTag;
    logic [IMM_W-1:0] immVal;
    rst = 1'b1;
    uopReq = 1'b0;
    uopOp = OP_ADD;
    uopFu = FU_INT;
    uopTagA = '0;
    uopTagB = '0;
    uopImmB = 1'b0;
    uopImm = '0;
    uopTagDst = '0;
    uopSqN = '0;
    lfsrState = 32'h4b80_b27c;
    errors = 0;
    errorsBefore = 0;
    testCount = 0;
    failedTests = 0;
    issued = 0;
    ackWait = 0;
    timedOut = 1'b0;
    nextSqN = '0;
    lastDst = '0;
    for (r = 0; r < NUM_REGS; r++) begin
        modelRegs[r] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Quiet bus, then every register reads back as zero
    repeat (8) begin
        @(negedge clk);
        checkBit("wbValid", wbValid, 1'b0);
        checkBit("uopAck", uopAck, 1'b0);
    end
    for (r = 0; r < NUM_REGS; r++) begin
        sendUop(OP_ADD, TAG_W'(r), '0, 1'b1, '0, TAG_W'(r));
    end
    finishTest("reset state");

    for (k = 0; k < 40; k++) begin
        sendRandom(1'b0, 1'b0);
    end
    finishTest("independent INT");

    for (k = 0; k < 24; k++) begin
        sendRandom(1'b0, 1'b1);
    end
    finishTest("dependent INT chains");

    // INT right behind each MUL, every other one reading the MUL result
    for (k = 0; k < 16; k++) begin
        sendRandom(1'b1, 1'b0);
        sendRandom(1'b0, 1'(k));
    end
    finishTest("MUL and INT mix");

    for (k = 0; k < 8; k++) begin
        wawTag = TAG_W'(randBits(TAG_W));
        srcTag = TAG_W'(randBits(TAG_W));
        immVal = randBits(IMM_W);
        sendUop(OP_MUL, srcTag, wawTag, 1'b0, '0, wawTag);
        sendUop(OP_ADD, srcTag, '0, 1'b1, immVal, wawTag);
        if (!timedOut && ackWait < 2) begin
            $display("Write to r%0d was accepted while an older write to it was pending",
                     wawTag);
            errors++;
        end
        sendUop(OP_ADD, wawTag, '0, 1'b1, '0, wawTag);
    end
    finishTest("write-after-write");

    endRun();
end

endmodule

// ==== verilog/Core.sv ====
`timescale 1ns/1ps

module Core
    import CorePkg::*;
#(
    parameter int NUM_REGS = 64
)
(
    input  logic              clk,
    input  logic              rst,

    input  logic              uopReq,
    input  AluOp              uopOp,
    input  FuncUnit           uopFu,
    input  logic [TAG_W-1:0]  uopTagA,
    input  logic [TAG_W-1:0]  uopTagB,
    input  logic              uopImmB,
    input  logic [IMM_W-1:0]  uopImm,
    input  logic [TAG_W-1:0]  uopTagDst,
    input  logic [SQN_W-1:0]  uopSqN,
    output logic              uopAck,

    output logic              wbValid,
    output logic [TAG_W-1:0]  wbTag,
    output logic [XLEN-1:0]   wbResult,
    output logic [SQN_W-1:0]  wbSqN
);

logic wbStall;

logic issValid;
AluOp issOp;
FuncUnit issFu;
logic [TAG_W-1:0] issTagA;
logic [TAG_W-1:0] issTagB;
logic issImmB;
logic [IMM_W-1:0] issImm;
logic [TAG_W-1:0] issTagDst;
logic [SQN_W-1:0] issSqN;

logic [TAG_W-1:0] rfAddrA;
logic [TAG_W-1:0] rfAddrB;
logic [XLEN-1:0] rfDataA;
logic [XLEN-1:0] rfDataB;

logic exValid;
AluOp exOp;
FuncUnit exFu;
logic [XLEN-1:0] exSrcA;
logic [XLEN-1:0] exSrcB;
logic [TAG_W-1:0] exTagDst;
logic [SQN_W-1:0] exSqN;

logic intValid;
logic [TAG_W-1:0] intTag;
logic [XLEN-1:0] intResult;
logic [SQN_W-1:0] intSqN;
logic mulValid;
logic [TAG_W-1:0] mulTag;
logic [XLEN-1:0] mulResult;
logic [SQN_W-1:0] mulSqN;

IssueGate #(.NUM_REGS(NUM_REGS)) IssueGate_i (
    .clk(clk), .rst(rst),
    .uopReq(uopReq), .uopOp(uopOp), .uopFu(uopFu),
    .uopTagA(uopTagA), .uopTagB(uopTagB), .uopImmB(uopImmB), .uopImm(uopImm),
    .uopTagDst(uopTagDst), .uopSqN(uopSqN), .uopAck(uopAck),
    .stall(wbStall), .wbValid(wbValid), .wbTag(wbTag),
    .issValid(issValid), .issOp(issOp), .issFu(issFu),
    .issTagA(issTagA), .issTagB(issTagB), .issImmB(issImmB), .issImm(issImm),
    .issTagDst(issTagDst), .issSqN(issSqN)
);

RegFile #(.NUM_REGS(NUM_REGS)) RegFile_i (
    .clk(clk), .rst(rst),
    .rdAddrA(rfAddrA), .rdAddrB(rfAddrB),
    .rdDataA(rfDataA), .rdDataB(rfDataB),
    .wrEn(wbValid), .wrAddr(wbTag), .wrData(wbResult)
);

OperandLoad OperandLoad_i (
    .clk(clk), .rst(rst), .stall(wbStall),
    .issValid(issValid), .issOp(issOp), .issFu(issFu),
    .issTagA(issTagA), .issTagB(issTagB), .issImmB(issImmB), .issImm(issImm),
    .issTagDst(issTagDst), .issSqN(issSqN),
    .rfAddrA(rfAddrA), .rfAddrB(rfAddrB), .rfDataA(rfDataA), .rfDataB(rfDataB),
    .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult),
    .zcValid(intValid), .zcTag(intTag), .zcResult(intResult),
    .exValid(exValid), .exOp(exOp), .exFu(exFu), .exSrcA(exSrcA), .exSrcB(exSrcB),
    .exTagDst(exTagDst), .exSqN(exSqN)
);

ExecUnit ExecUnit_i (
    .clk(clk), .rst(rst), .stall(wbStall),
    .exValid(exValid), .exOp(exOp), .exFu(exFu), .exSrcA(exSrcA), .exSrcB(exSrcB),
    .exTagDst(exTagDst), .exSqN(exSqN),
    .intValid(intValid), .intTag(intTag), .intResult(intResult), .intSqN(intSqN),
    .mulValid(mulValid), .mulTag(mulTag), .mulResult(mulResult), .mulSqN(mulSqN)
);

Writeback Writeback_i (
    .clk(clk), .rst(rst),
    .intValid(intValid), .intTag(intTag), .intResult(intResult), .intSqN(intSqN),
    .mulValid(mulValid), .mulTag(mulTag), .mulResult(mulResult), .mulSqN(mulSqN),
    .wbStall(wbStall), .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult),
    .wbSqN(wbSqN)
);

endmodule

// ==== verilog/Writeback.sv ====
`timescale 1ns/1ps

module Writeback
    import CorePkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              intValid,
    input  logic [TAG_W-1:0]  intTag,
    input  logic [XLEN-1:0]   intResult,
    input  logic [SQN_W-1:0]  intSqN,

    input  logic              mulValid,
    input  logic [TAG_W-1:0]  mulTag,
    input  logic [XLEN-1:0]   mulResult,
    input  logic [SQN_W-1:0]  mulSqN,

    output logic              wbStall,
    output logic              wbValid,
    output logic [TAG_W-1:0]  wbTag,
    output logic [XLEN-1:0]   wbResult,
    output logic [SQN_W-1:0]  wbSqN
);

// MUL wins because its pipe cannot hold
assign wbStall = mulValid && intValid;

always_ff @(posedge clk) begin
    if (rst) begin
        wbValid <= 1'b0;
    end
    else begin
        wbValid <= mulValid || intValid;
    end
end

always_ff @(posedge clk) begin
    if (mulValid) begin
        wbTag <= mulTag;
        wbResult <= mulResult;
        wbSqN <= mulSqN;
    end
    else if (intValid) begin
        wbTag <= intTag;
        wbResult <= intResult;
        wbSqN <= intSqN;
    end
end

// The losing INT result is offered again in the next cycle
intHeldOnStall: assert property (@(posedge clk) disable iff (rst)
    wbStall |=> intValid && intTag == $past(intTag) && intSqN == $past(intSqN))
    else $error("INT result dropped after a writeback stall");

endmodule

// ==== verilog/ExecUnit.sv ====
`timescale 1ns/1ps

module ExecUnit
    import CorePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,

    input  logic              exValid,
    input  AluOp              exOp,
    input  FuncUnit           exFu,
    input  logic [XLEN-1:0]   exSrcA,
    input  logic [XLEN-1:0]   exSrcB,
    input  logic [TAG_W-1:0]  exTagDst,
    input  logic [SQN_W-1:0]  exSqN,

    output logic              intValid,
    output logic [TAG_W-1:0]  intTag,
    output logic [XLEN-1:0]   intResult,
    output logic [SQN_W-1:0]  intSqN,

    output logic              mulValid,
    output logic [TAG_W-1:0]  mulTag,
    output logic [XLEN-1:0]   mulResult,
    output logic [SQN_W-1:0]  mulSqN
);

localparam int HALF = XLEN / 2;

logic            m1Valid;
logic [XLEN-1:0] m1Low;
logic [HALF-1:0] m1Cross;
logic [TAG_W-1:0] m1Tag;
logic [SQN_W-1:0] m1SqN;

// Input is held under stall, so the same INT result is offered again
assign intValid = exValid && exFu == FU_INT;
assign intTag = exTagDst;
assign intSqN = exSqN;

always_comb begin
    case (exOp)
        OP_ADD: intResult = exSrcA + exSrcB;
        OP_SUB: intResult = exSrcA - exSrcB;
        OP_AND: intResult = exSrcA & exSrcB;
        OP_XOR: intResult = exSrcA ^ exSrcB;
        OP_SLT: intResult = {{(XLEN-1){1'b0}}, $signed(exSrcA) < $signed(exSrcB)};
        default: intResult = '0;
    endcase
end

// Stage 1 builds partial products, stage 2 sums them (low half only)
always_ff @(posedge clk) begin
    if (rst) begin
        m1Valid <= 1'b0;
        mulValid <= 1'b0;
    end
    else begin
        m1Valid <= exValid && exFu == FU_MUL && !stall;
        mulValid <= m1Valid;
    end
end

always_ff @(posedge clk) begin
    m1Low <= exSrcA[HALF-1:0] * exSrcB[HALF-1:0];
    m1Cross <= exSrcA[HALF-1:0] * exSrcB[XLEN-1:HALF] + exSrcA[XLEN-1:HALF] * exSrcB[HALF-1:0];
    m1Tag <= exTagDst;
    m1SqN <= exSqN;

    mulResult <= m1Low + {m1Cross, {HALF{1'b0}}};
    mulTag <= m1Tag;
    mulSqN <= m1SqN;
end

fuMatchesOp: assert property (@(posedge clk) disable iff (rst)
    exValid |-> ((exOp == OP_MUL) == (exFu == FU_MUL)))
    else $error("exOp and exFu disagree");

endmodule

// ==== verilog/OperandLoad.sv ====
`timescale 1ns/1ps

module OperandLoad
    import CorePkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // Keeps the previous output on writeback contention
    input  logic              stall,

    input  logic              issValid,
    input  AluOp              issOp,
    input  FuncUnit           issFu,
    input  logic [TAG_W-1:0]  issTagA,
    input  logic [TAG_W-1:0]  issTagB,
    input  logic              issImmB,
    input  logic [IMM_W-1:0]  issImm,
    input  logic [TAG_W-1:0]  issTagDst,
    input  logic [SQN_W-1:0]  issSqN,

    output logic [TAG_W-1:0]  rfAddrA,
    output logic [TAG_W-1:0]  rfAddrB,
    input  logic [XLEN-1:0]   rfDataA,
    input  logic [XLEN-1:0]   rfDataB,

    // Writeback snoop
    input  logic              wbValid,
    input  logic [TAG_W-1:0]  wbTag,
    input  logic [XLEN-1:0]   wbResult,

    // Zero cycle forward from the ALU
    input  logic              zcValid,
    input  logic [TAG_W-1:0]  zcTag,
    input  logic [XLEN-1:0]   zcResult,

    output logic              exValid,
    output AluOp              exOp,
    output FuncUnit           exFu,
    output logic [XLEN-1:0]   exSrcA,
    output logic [XLEN-1:0]   exSrcB,
    output logic [TAG_W-1:0]  exTagDst,
    output logic [SQN_W-1:0]  exSqN
);

logic [XLEN-1:0] srcA;
logic [XLEN-1:0] srcB;

assign rfAddrA = issTagA;
assign rfAddrB = issTagB;

// Newest value first
always_comb begin
    if (zcValid && zcTag == issTagA) begin
        srcA = zcResult;
    end
    else if (wbValid && wbTag == issTagA) begin
        srcA = wbResult;
    end
    else begin
        srcA = rfDataA;
    end
end

always_comb begin
    if (issImmB) begin
        srcB = issImm;
    end
    else if (zcValid && zcTag == issTagB) begin
        srcB = zcResult;
    end
    else if (wbValid && wbTag == issTagB) begin
        srcB = wbResult;
    end
    else begin
        srcB = rfDataB;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        exValid <= 1'b0;
    end
    else if (!stall) begin
        exValid <= issValid;
    end
end

always_ff @(posedge clk) begin
    if (!stall && issValid) begin
        exOp <= issOp;
        exFu <= issFu;
        exSrcA <= srcA;
        exSrcB <= srcB;
        exTagDst <= issTagDst;
        exSqN <= issSqN;
    end
end

endmodule

// ==== verilog/RegFile.sv ====
`timescale 1ns/1ps

module RegFile
    import CorePkg::*;
#(
    parameter int NUM_REGS = 64
)
(
    input  logic              clk,
    input  logic              rst,

    input  logic [TAG_W-1:0]  rdAddrA,
    input  logic [TAG_W-1:0]  rdAddrB,
    output logic [XLEN-1:0]   rdDataA,
    output logic [XLEN-1:0]   rdDataB,

    input  logic              wrEn,
    input  logic [TAG_W-1:0]  wrAddr,
    input  logic [XLEN-1:0]   wrData
);

logic [XLEN-1:0] regs [NUM_REGS-1:0];

// A same-cycle write shows up on the read ports next cycle
assign rdDataA = regs[rdAddrA];
assign rdDataB = regs[rdAddrB];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end
    else if (wrEn) begin
        regs[wrAddr] <= wrData;
    end
end

endmodule

// ==== verilog/IssueGate.sv ====
`timescale 1ns/1ps

module IssueGate
    import CorePkg::*;
#(
    parameter int NUM_REGS = 64
)
(
    input  logic              clk,
    input  logic              rst,

    input  logic              uopReq,
    input  AluOp              uopOp,
    input  FuncUnit           uopFu,
    input  logic [TAG_W-1:0]  uopTagA,
    input  logic [TAG_W-1:0]  uopTagB,
    input  logic              uopImmB,
    input  logic [IMM_W-1:0]  uopImm,
    input  logic [TAG_W-1:0]  uopTagDst,
    input  logic [SQN_W-1:0]  uopSqN,
    output logic              uopAck,

    input  logic              stall,
    input  logic              wbValid,
    input  logic [TAG_W-1:0]  wbTag,

    output logic              issValid,
    output AluOp              issOp,
    output FuncUnit           issFu,
    output logic [TAG_W-1:0]  issTagA,
    output logic [TAG_W-1:0]  issTagB,
    output logic              issImmB,
    output logic [IMM_W-1:0]  issImm,
    output logic [TAG_W-1:0]  issTagDst,
    output logic [SQN_W-1:0]  issSqN
);

logic [NUM_REGS-1:0] busy;
logic [NUM_REGS-1:0] free;
logic canIssue;

// A tag being written back this cycle counts as free
always_comb begin
    for (int i = 0; i < NUM_REGS; i++) begin
        free[i] = !busy[i] || (wbValid && wbTag == TAG_W'(i));
    end
end

assign canIssue = uopReq && !uopAck && !stall &&
                  free[uopTagA] && (uopImmB || free[uopTagB]) && free[uopTagDst];

always_ff @(posedge clk) begin
    if (rst) begin
        uopAck <= 1'b0;
        issValid <= 1'b0;
        busy <= '0;
    end
    else begin
        if (canIssue) begin
            uopAck <= 1'b1;
        end
        else if (uopAck && !uopReq) begin
            uopAck <= 1'b0;
        end

        // Held while stalled so OperandLoad still sees the micro-op
        if (!stall) begin
            issValid <= canIssue;
        end

        for (int i = 0; i < NUM_REGS; i++) begin
            if (wbValid && wbTag == TAG_W'(i)) begin
                busy[i] <= 1'b0;
            end
        end
        // set after clear, so a new owner of the tag wins
        if (canIssue) begin
            busy[uopTagDst] <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (canIssue) begin
        issOp <= uopOp;
        issFu <= uopFu;
        issTagA <= uopTagA;
        issTagB <= uopTagB;
        issImmB <= uopImmB;
        issImm <= uopImm;
        issTagDst <= uopTagDst;
        issSqN <= uopSqN;
    end
end

// Ack only ever answers a live request
ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
    $rose(uopAck) |-> uopReq)
    else $error("uopAck rose without uopReq");

endmodule

// ==== verilog/CorePkg.sv ====
package CorePkg;

    // Physical register tag and sequence number widths
    localparam int TAG_W = 6;
    localparam int SQN_W = 6;

    localparam int XLEN = 32;
    localparam int IMM_W = 32;

    typedef enum logic [0:0] {
        FU_INT,
        FU_MUL
    } FuncUnit;

    // OP_MUL only goes with FU_MUL
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_SLT,
        OP_MUL
    } AluOp;

endpackage
